// ==== src/vmem_pkg.sv ====
`default_nettype none

package vmem_pkg;

    // Vector geometry and memory depth
    localparam int NUM_LANES = 4;
    localparam int RAM_WORDS = 256;

    // Word address field inside a byte address
    localparam int RAM_ADDR_LSB = 2;
    localparam int RAM_ADDR_MSB = 9;

    // Scalar widths
    typedef logic [31:0] word_t;
    typedef logic [NUM_LANES-1:0] lane_mask_t;
    typedef logic [1:0] lane_idx_t;
    typedef logic [3:0] byte_en_t;
    typedef logic [1:0] eew_t;
    typedef logic [RAM_ADDR_MSB-RAM_ADDR_LSB:0] ram_addr_t;

    // One entry per lane
    typedef word_t [NUM_LANES-1:0] lane_words_t;
    typedef byte_en_t [NUM_LANES-1:0] lane_bytes_t;

    // Element width codes
    localparam eew_t EEW_BYTE = 2'd0;
    localparam eew_t EEW_HALF = 2'd1;
    localparam eew_t EEW_WORD = 2'd2;
    localparam eew_t EEW_BAD  = 2'd3;

    // Serializer states
    typedef enum logic [2:0] {
        IDLE,
        ISSUE,
        WAIT,
        NEXT,
        FINISH
    } slzr_state_t;

endpackage

`default_nettype wire

// ==== src/lane_access_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface lane_access_if;
    import vmem_pkg::*;

    // Request side, one element per req pulse
    logic  req;
    logic  we;
    word_t addr;
    word_t wdata;
    eew_t  eew;

    // Response side
    logic  ack;
    word_t rdata;
    logic  mal;

    modport slzr (
        output req, we, addr, wdata, eew,
        input  ack, rdata, mal
    );

    modport lsu (
        input  req, we, addr, wdata, eew,
        output ack, rdata, mal
    );

endinterface

`default_nettype wire

// ==== src/ram_port_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface ram_port_if;
    import vmem_pkg::*;

    logic      en;
    logic      we;
    ram_addr_t addr;
    byte_en_t  be;
    word_t     wdata;
    word_t     rdata;

    modport master (
        output en, we, addr, be, wdata,
        input  rdata
    );

    modport slave (
        input  en, we, addr, be, wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== src/lane_serializer.sv ====
`timescale 1ns/1ns
`default_nettype none

module lane_serializer (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  op_valid,
    input  logic                  op_store,
    input  logic                  op_indexed,
    input  vmem_pkg::eew_t        op_eew,
    input  vmem_pkg::word_t       op_base,
    input  vmem_pkg::word_t       op_stride,
    input  vmem_pkg::lane_mask_t  op_lane_mask,
    input  vmem_pkg::lane_words_t op_index,
    input  vmem_pkg::lane_words_t op_store_data,
    lane_access_if.slzr           acc,
    output logic                  busy,
    output logic                  done,
    output vmem_pkg::lane_mask_t  fault_mask,
    output vmem_pkg::lane_idx_t   cur_lane,
    output logic                  cap,
    output logic                  clear,
    output logic                  finish
);
    import vmem_pkg::*;

    slzr_state_t state;
    slzr_state_t state_n;
    logic        accept;
    lane_mask_t  pending;
    lane_mask_t  pending_left;
    word_t       lane_off;

    // Operation held for the whole walk
    logic        store_q;
    logic        indexed_q;
    eew_t        eew_q;
    word_t       base_q;
    word_t       stride_q;
    lane_words_t index_q;
    lane_words_t sdata_q;

    // Lowest lane still waiting
    function automatic lane_idx_t first_lane(input lane_mask_t m);
        lane_idx_t idx;
        idx = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = lane_idx_t'(i);
            end
        end
        return idx;
    endfunction

    assign accept       = (state == IDLE) && op_valid;
    assign cur_lane     = first_lane(pending);
    assign pending_left = pending & ~(lane_mask_t'(1) << cur_lane);

    // Strided or indexed lane offset
    assign lane_off = indexed_q ? index_q[cur_lane] : stride_q * word_t'(cur_lane);

    assign acc.req   = (state == ISSUE);
    assign acc.we    = store_q;
    assign acc.addr  = base_q + lane_off;
    assign acc.wdata = sdata_q[cur_lane];
    assign acc.eew   = eew_q;

    assign busy   = (state != IDLE);
    assign cap    = (state == WAIT) && acc.ack && !store_q;
    assign clear  = accept;
    assign finish = (state == FINISH);

    always_comb begin
        state_n = state;
        case (state)
            IDLE: begin
                if (op_valid) begin
                    state_n = (op_lane_mask != '0) ? ISSUE : FINISH;
                end
            end
            ISSUE:   state_n = acc.mal ? NEXT : WAIT;
            WAIT: begin
                if (acc.ack) begin
                    state_n = NEXT;
                end
            end
            NEXT:    state_n = (pending_left != '0) ? ISSUE : FINISH;
            FINISH:  state_n = IDLE;
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state      <= IDLE;
            pending    <= '0;
            fault_mask <= '0;
            done       <= 1'b0;
        end else begin
            state <= state_n;
            done  <= (state == FINISH);
            if (accept) begin
                pending    <= op_lane_mask;
                fault_mask <= '0;
            end else if (state == NEXT) begin
                pending <= pending_left;
            end
            // Misaligned lane is dropped and flagged
            if ((state == ISSUE) && acc.mal) begin
                fault_mask[cur_lane] <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            store_q   <= op_store;
            indexed_q <= op_indexed;
            eew_q     <= op_eew;
            base_q    <= op_base;
            stride_q  <= op_stride;
            index_q   <= op_index;
            sdata_q   <= op_store_data;
        end
    end

    // Every request targets a lane that is still pending
    a_req_pending_lane: assert property (@(posedge CLK) disable iff (rst)
        acc.req |-> pending[cur_lane]);

    // The LSU answers only while the FSM waits for it
    a_ack_in_wait: assert property (@(posedge CLK) disable iff (rst)
        acc.ack |-> (state == WAIT));

endmodule

`default_nettype wire

// ==== src/load_store_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module load_store_unit (
    input  logic            CLK,
    input  logic            rst,
    lane_access_if.lsu      acc,
    ram_port_if.master      ram,
    output vmem_pkg::word_t load_data
);
    import vmem_pkg::*;

    logic       misaligned;
    byte_en_t   be_elem;
    logic       ack_q;
    logic [1:0] off_q;
    eew_t       eew_q;
    word_t      shifted;

    // Alignment check and unshifted byte enables per width
    always_comb begin
        case (acc.eew)
            EEW_BYTE: begin
                misaligned = 1'b0;
                be_elem    = 4'b0001;
            end
            EEW_HALF: begin
                misaligned = acc.addr[0];
                be_elem    = 4'b0011;
            end
            EEW_WORD: begin
                misaligned = (acc.addr[1:0] != 2'b00);
                be_elem    = 4'b1111;
            end
            default: begin
                misaligned = 1'b1;
                be_elem    = 4'b0000;
            end
        endcase
    end

    assign acc.mal   = acc.req && misaligned;
    assign ram.en    = acc.req && !misaligned;
    assign ram.we    = acc.we;
    assign ram.addr  = acc.addr[RAM_ADDR_MSB:RAM_ADDR_LSB];
    assign ram.be    = be_elem << acc.addr[1:0];
    // Move store element onto its byte lanes
    assign ram.wdata = acc.wdata << {acc.addr[1:0], 3'b000};

    always_ff @(posedge CLK) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= ram.en;
        end
    end

    // Remember where the element sits for the returning word
    always_ff @(posedge CLK) begin
        if (ram.en) begin
            off_q <= acc.addr[1:0];
            eew_q <= acc.eew;
        end
    end

    assign acc.ack = ack_q;
    assign shifted = ram.rdata >> {off_q, 3'b000};

    always_comb begin
        case (eew_q)
            EEW_BYTE: load_data = {24'b0, shifted[7:0]};
            EEW_HALF: load_data = {16'b0, shifted[15:0]};
            default:  load_data = shifted;
        endcase
    end

    assign acc.rdata = load_data;

    // Serializer must never hand over the reserved width code
    a_eew_valid: assert property (@(posedge CLK) disable iff (rst)
        acc.req |-> (acc.eew != EEW_BAD));

endmodule

`default_nettype wire

// ==== src/data_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_ram (
    input logic       CLK,
    ram_port_if.slave ram
);
    import vmem_pkg::*;

    word_t mem [RAM_WORDS];

    // Memory starts cleared
    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Byte-masked write, read returns the old word
    always_ff @(posedge CLK) begin
        if (ram.en) begin
            if (ram.we) begin
                for (int b = 0; b < $bits(byte_en_t); b++) begin
                    if (ram.be[b]) begin
                        mem[ram.addr][8*b +: 8] <= ram.wdata[8*b +: 8];
                    end
                end
            end
            ram.rdata <= mem[ram.addr];
        end
    end

endmodule

`default_nettype wire

// ==== src/wb_collector.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_collector (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  cap,
    input  logic                  finish,
    input  vmem_pkg::lane_idx_t   cur_lane,
    input  vmem_pkg::eew_t        op_eew,
    input  vmem_pkg::word_t       load_data,
    output vmem_pkg::lane_words_t wb_data,
    output vmem_pkg::lane_bytes_t wb_byte_en
);
    import vmem_pkg::*;

    lane_words_t stage_data;
    lane_bytes_t stage_be;
    byte_en_t    elem_be;

    // Element sits at the bottom of its bank
    always_comb begin
        case (op_eew)
            EEW_BYTE: elem_be = 4'b0001;
            EEW_HALF: elem_be = 4'b0011;
            EEW_WORD: elem_be = 4'b1111;
            default:  elem_be = 4'b0000;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            stage_be <= '0;
        end else if (clear) begin
            stage_be <= '0;
        end else if (cap) begin
            stage_be[cur_lane] <= elem_be;
        end
    end

    always_ff @(posedge CLK) begin
        if (clear) begin
            stage_data <= '0;
        end else if (cap) begin
            stage_data[cur_lane] <= load_data;
        end
    end

    // Publish the gathered banks at the end of the op
    always_ff @(posedge CLK) begin
        if (rst) begin
            wb_byte_en <= '0;
        end else if (finish) begin
            wb_byte_en <= stage_be;
        end
    end

    always_ff @(posedge CLK) begin
        if (finish) begin
            wb_data <= stage_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/vmem_stage_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module vmem_stage_top (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  op_valid,
    input  logic                  op_store,
    input  logic                  op_indexed,
    input  vmem_pkg::eew_t        op_eew,
    input  vmem_pkg::word_t       op_base,
    input  vmem_pkg::word_t       op_stride,
    input  vmem_pkg::lane_mask_t  op_lane_mask,
    input  vmem_pkg::lane_words_t op_index,
    input  vmem_pkg::lane_words_t op_store_data,
    output logic                  busy,
    output logic                  done,
    output vmem_pkg::lane_mask_t  fault_mask,
    output vmem_pkg::lane_words_t wb_data,
    output vmem_pkg::lane_bytes_t wb_byte_en
);
    import vmem_pkg::*;

    lane_idx_t cur_lane;
    logic      cap;
    logic      clear;
    logic      finish;
    word_t     load_data;

    lane_access_if acc();
    ram_port_if    ram();

    // Lane walker
    lane_serializer slzr_inst (
        .CLK,
        .rst,
        .op_valid,
        .op_store,
        .op_indexed,
        .op_eew,
        .op_base,
        .op_stride,
        .op_lane_mask,
        .op_index,
        .op_store_data,
        .acc,
        .busy,
        .done,
        .fault_mask,
        .cur_lane,
        .cap,
        .clear,
        .finish
    );

    load_store_unit lsu_inst (
        .CLK,
        .rst,
        .acc,
        .ram,
        .load_data
    );

    data_ram ram_inst (
        .CLK,
        .ram
    );

    // Width of the current op comes from the latched request
    wb_collector wbc_inst (
        .CLK,
        .rst,
        .clear,
        .cap,
        .finish,
        .cur_lane,
        .op_eew(acc.eew),
        .load_data,
        .wb_data,
        .wb_byte_en
    );

endmodule

`default_nettype wire

// ==== verif/vmem_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module vmem_checker (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  done,
    input  logic                  busy,
    input  vmem_pkg::lane_mask_t  fault_mask,
    input  vmem_pkg::lane_words_t wb_data,
    input  vmem_pkg::lane_bytes_t wb_byte_en,
    input  logic [127:0]          test_name,
    input  vmem_pkg::lane_mask_t  exp_fault,
    input  vmem_pkg::lane_words_t exp_data,
    input  vmem_pkg::lane_bytes_t exp_be,
    output int                    err_count,
    output int                    check_count,
    output int                    done_count
);
    import vmem_pkg::*;

    // Prints one mismatch and returns how many were found
    function automatic int report_mismatch(input logic [127:0] name, input string field,
                                           input logic [127:0] expected,
                                           input logic [127:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %0s %0s expected %0h actual %0h", name, field, expected,
                actual);
            return 1;
        end
        return 0;
    endfunction

    always @(posedge CLK) begin
        int errs;
        errs = 0;
        if (rst) begin
            err_count   <= 0;
            check_count <= 0;
            done_count  <= 0;
        end else if (done) begin
            errs += report_mismatch(test_name, "fault_mask", 128'(exp_fault),
                128'(fault_mask));
            errs += report_mismatch(test_name, "wb_data", exp_data, wb_data);
            errs += report_mismatch(test_name, "wb_byte_en", 128'(exp_be),
                128'(wb_byte_en));
            // busy must already be low when done pulses
            errs += report_mismatch(test_name, "busy", 128'(1'b0), 128'(busy));
            err_count   <= err_count + errs;
            check_count <= check_count + 4;
            done_count  <= done_count + 1;
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_vmem_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_vmem_stage;
    import vmem_pkg::*;

    localparam int MAX_OPS = 32;

    logic        CLK;
    logic        rst;
    logic        op_valid;
    logic        op_store;
    logic        op_indexed;
    eew_t        op_eew;
    word_t       op_base;
    word_t       op_stride;
    lane_mask_t  op_lane_mask;
    lane_words_t op_index;
    lane_words_t op_store_data;
    logic        busy;
    logic        done;
    lane_mask_t  fault_mask;
    lane_words_t wb_data;
    lane_bytes_t wb_byte_en;

    // One entry per stimulus line
    logic [127:0] t_name [MAX_OPS];
    logic         t_poke [MAX_OPS];
    logic         t_store [MAX_OPS];
    logic         t_indexed [MAX_OPS];
    eew_t         t_eew [MAX_OPS];
    word_t        t_base [MAX_OPS];
    word_t        t_stride [MAX_OPS];
    lane_mask_t   t_mask [MAX_OPS];
    lane_words_t  t_index [MAX_OPS];
    lane_words_t  t_sdata [MAX_OPS];
    lane_mask_t   t_fault [MAX_OPS];
    lane_words_t  t_wdata [MAX_OPS];
    lane_bytes_t  t_be [MAX_OPS];

    // Expected results of the op in flight
    logic [127:0] cur_name;
    lane_mask_t   exp_fault;
    lane_words_t  exp_data;
    lane_bytes_t  exp_be;

    int n_ops;
    int limit = 0;
    int cycles;
    int tb_errors = 0;
    int err_count;
    int check_count;
    int done_count;

    vmem_stage_top vmem_stage_top_inst (.*);

    vmem_checker checker_inst (
        .CLK, .rst, .done, .busy, .fault_mask, .wb_data, .wb_byte_en,
        .test_name(cur_name), .exp_fault, .exp_data, .exp_be,
        .err_count, .check_count, .done_count
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic load_stimulus();
        int    fd;
        int    code;
        string line;
        n_ops = 0;
        fd = $fopen("verif/vmem_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/vmem_stimulus.txt");
            tb_errors++;
        end else begin
            while (!$feof(fd) && n_ops < MAX_OPS) begin
                code = $fgets(line, fd);
                // Skip blank and comment lines
                if (code > 1 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h",
                        t_name[n_ops], t_poke[n_ops], t_store[n_ops], t_indexed[n_ops],
                        t_eew[n_ops], t_base[n_ops], t_stride[n_ops], t_mask[n_ops],
                        t_index[n_ops], t_sdata[n_ops], t_fault[n_ops], t_wdata[n_ops],
                        t_be[n_ops]);
                    if (code == 13) begin
                        n_ops++;
                    end else begin
                        $display("Stimulus line could not be parsed: %0s", line);
                        tb_errors++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_ops == 0) begin
            $display("No operations were read from the stimulus file");
            tb_errors++;
        end
    endtask

    // Issue one op, optionally poke op_valid mid-walk, then wait for done
    task automatic run_op(input int i);
        cur_name      <= t_name[i];
        exp_fault     <= t_fault[i];
        exp_data      <= t_wdata[i];
        exp_be        <= t_be[i];
        op_store      <= t_store[i];
        op_indexed    <= t_indexed[i];
        op_eew        <= t_eew[i];
        op_base       <= t_base[i];
        op_stride     <= t_stride[i];
        op_lane_mask  <= t_mask[i];
        op_index      <= t_index[i];
        op_store_data <= t_sdata[i];
        op_valid      <= 1'b1;
        @(posedge CLK);
        op_valid <= 1'b0;
        if (t_poke[i]) begin
            repeat (2) @(posedge CLK);
            if (!busy) begin
                $display("Extra op_valid in %0s was not issued while busy", t_name[i]);
                tb_errors++;
            end
            op_valid <= 1'b1;
            @(posedge CLK);
            op_valid <= 1'b0;
        end
        do @(posedge CLK); while (!done);
    endtask

    task automatic print_summary();
        $display("Done pulses: %0d of %0d ops, checks: %0d, errors: %0d",
            done_count, n_ops, check_count, err_count + tb_errors);
    endtask

    initial begin
        rst           = 1'b1;
        op_valid      = 1'b0;
        op_store      = 1'b0;
        op_indexed    = 1'b0;
        op_eew        = EEW_WORD;
        op_base       = '0;
        op_stride     = '0;
        op_lane_mask  = '0;
        op_index      = '0;
        op_store_data = '0;
        cur_name      = '0;
        exp_fault     = '0;
        exp_data      = '0;
        exp_be        = '0;
        load_stimulus();
        limit = n_ops * 20 + 50;
        repeat (2) @(posedge CLK);
        rst <= 1'b0;
        for (int i = 0; i < n_ops; i++) begin
            run_op(i);
        end
        // Leave room for a stray op to show up
        repeat (10) @(posedge CLK);
        if (done_count != n_ops) begin
            $display("Saw %0d done pulses for %0d accepted ops", done_count, n_ops);
            tb_errors++;
        end
        print_summary();
        if (err_count + tb_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog
    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge CLK);
            cycles++;
        end
        $display("The run hung and was stopped after %0d cycles", limit);
        tb_errors++;
        print_summary();
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/vmem_stimulus.txt ====
# name poke store indexed eew base stride lane_mask index store_data exp_fault exp_wb_data exp_be
# all values hex, 128-bit fields hold lanes 3..0 from left to right
st_word_strd 0 1 0 2 00000100 00000004 f 00000000000000000000000000000000 ddeeff0099aabbcc5566778811223344 0 00000000000000000000000000000000 0000
ld_word_strd 0 0 0 2 00000100 00000004 f 00000000000000000000000000000000 00000000000000000000000000000000 0 ddeeff0099aabbcc5566778811223344 ffff
ld_byte_strd 0 0 0 0 00000101 00000004 f 00000000000000000000000000000000 00000000000000000000000000000000 0 000000ff000000bb0000007700000033 1111
ld_half_strd 0 0 0 1 00000102 00000004 f 00000000000000000000000000000000 00000000000000000000000000000000 0 0000ddee000099aa0000556600001122 3333
ld_word_idx 0 0 1 2 00000100 00000000 f 0000000400000008000000000000000c 00000000000000000000000000000000 0 5566778899aabbcc11223344ddeeff00 ffff
ld_byte_idx 0 0 1 0 00000100 00000000 f 0000000c000000090000000600000003 00000000000000000000000000000000 0 00000000000000bb0000006600000011 1111
st_word_mask 0 1 0 2 00000200 00000004 5 00000000000000000000000000000000 d3d3d3d3c2c2c2c2b1b1b1b1a0a0a0a0 0 00000000000000000000000000000000 0000
ld_word_mask 0 0 0 2 00000200 00000004 a 00000000000000000000000000000000 00000000000000000000000000000000 0 00000000000000000000000000000000 f0f0
ld_word_all 0 0 0 2 00000200 00000004 f 00000000000000000000000000000000 00000000000000000000000000000000 0 00000000c2c2c2c200000000a0a0a0a0 ffff
st_half_mis 0 1 0 1 00000300 00000003 f 00000000000000000000000000000000 0000f00d0000cafe0000dead0000beef a 00000000000000000000000000000000 0000
ld_word_chk 0 0 0 2 00000300 00000004 f 00000000000000000000000000000000 00000000000000000000000000000000 0 0000000000000000cafe00000000beef ffff
ld_word_mis 0 0 0 2 00000100 00000002 f 00000000000000000000000000000000 00000000000000000000000000000000 a 00000000556677880000000011223344 0f0f
ld_half_busy 1 0 1 1 00000300 00000000 3 00000000000000000000000600000000 00000000000000000000000000000000 0 00000000000000000000cafe0000beef 0033
ld_no_lanes 0 0 0 2 00000100 00000004 0 00000000000000000000000000000000 00000000000000000000000000000000 0 00000000000000000000000000000000 0000
st_byte_strd 0 1 0 0 00000110 00000001 f 00000000000000000000000000000000 00000012000000ef000000cd000000ab 0 00000000000000000000000000000000 0000
ld_word_pack 0 0 0 2 00000110 00000000 1 00000000000000000000000000000000 00000000000000000000000000000000 0 00000000000000000000000012efcdab 000f

// ==== src.f ====
src/vmem_pkg.sv
src/lane_access_if.sv
src/ram_port_if.sv
src/lane_serializer.sv
src/load_store_unit.sv
src/data_ram.sv
src/wb_collector.sv
src/vmem_stage_top.sv
verif/vmem_checker.sv
verif/tb_vmem_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run from the project root, judge the result from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_vmem_stage \
    -f src.f -o sim_vmem > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_vmem > sim.log 2>&1 || { cat sim.log; echo "Simulation exited with an error"; exit 1; }
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1 || exit 0
